// File: design/sdmacPkg.sv
/*
 * Shared types and constants of the SCSI-to-memory DMA path
 *  - fifoWord_t   one data word, as a longword or as hi/lo halves
 *  - fifoEntry_t  FIFO entry with valid byte count and flush marker
 *  - busCycle_t   bus outputs of one 68030-style transfer
 *  - DSACK encodings, address steps, bytes per word
 */
`default_nettype none

package sdmacPkg;

    localparam int unsigned BytesPerWord = 4;

    // DSACK pair as {DSACK1_, DSACK0_}, both active low
    localparam logic [1:0] DsackNone = 2'b11;
    localparam logic [1:0] Dsack16   = 2'b01;

    // Address advance per longword and offset of the low half
    localparam logic [31:0] AddrStepLong = 32'd4;
    localparam logic [31:0] AddrStepHalf = 32'd2;

    typedef struct packed {
        logic [15:0] hiWord;
        logic [15:0] loWord;
    } halfWords_t;

    // Producer fills longWord, a 16-bit port is served from the halves
    typedef union packed {
        logic [31:0] longWord;
        halfWords_t  halves;
    } fifoWord_t;

    // validBytes runs 0 to 4, lastWord closes a flush
    typedef struct packed {
        fifoWord_t  data;
        logic [2:0] validBytes;
        logic       lastWord;
    } fifoEntry_t;

    // A half transfer carries its 16 bits on the high half of data
    typedef struct packed {
        logic [31:0] addr;
        fifoWord_t   data;
        logic        size16;
        logic        addrStrobe;
        logic        dataStrobe;
    } busCycle_t;

endpackage

`default_nettype wire

// File: design/scsiByteCollector.sv
/*
 * SCSI byte collector
 * Packs strobed SCSI bytes big-endian into longwords and pushes
 * them into the DMA FIFO. A rising flush pushes the partial word,
 * zero padded and marked as the last word.
 */
`timescale 1ns/1ps
`default_nettype none

module scsiByteCollector (
    input  wire                       BCLK,
    input  wire                       CCRESET_,
    input  wire [7:0]                 scsiByte,
    input  wire                       scsiStrobe,
    input  wire                       flushFifo,
    input  wire                       fifoFull,
    output logic                      scsiReady,
    output sdmacPkg::fifoEntry_t      pushEntry,
    output logic                      push
);

    logic [1:0]  byteOffset;
    logic [31:0] assembly;
    logic        flushDly;
    logic        boEq3;
    logic        flushRise;
    logic        wordDone;
    logic [2:0]  nextCount;
    logic [31:0] nextAssembly;
    logic [5:0]  padShift;

    // Byte offset 3 means the next strobe completes a longword
    assign boEq3     = (byteOffset == 2'd3);
    assign flushRise = flushFifo & ~flushDly;
    assign wordDone  = scsiStrobe & boEq3;

    // Include a byte strobed in the same cycle as the flush edge
    assign nextAssembly = scsiStrobe ? {assembly[23:0], scsiByte} : assembly;
    assign nextCount    = {1'b0, byteOffset} + {2'b00, scsiStrobe};

    // Moves pending bytes to the top, missing low bytes become zero
    assign padShift = {3'(sdmacPkg::BytesPerWord) - nextCount, 3'b000};

    assign scsiReady = ~fifoFull;

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            byteOffset <= 2'd0;
            flushDly   <= 1'b0;
            push       <= 1'b0;
        end else begin
            flushDly <= flushFifo;
            push     <= flushRise | wordDone;
            if (flushRise) begin
                byteOffset <= 2'd0;
            end else if (scsiStrobe) begin
                // Wraps from 3 back to 0 on a full word
                byteOffset <= byteOffset + 2'd1;
            end
        end
    end

    always_ff @(posedge BCLK) begin
        assembly <= nextAssembly;
        if (flushRise) begin
            pushEntry.data.longWord <= nextAssembly << padShift;
            pushEntry.validBytes    <= nextCount;
            pushEntry.lastWord      <= 1'b1;
        end else if (wordDone) begin
            pushEntry.data.longWord <= nextAssembly;
            pushEntry.validBytes    <= 3'(sdmacPkg::BytesPerWord);
            pushEntry.lastWord      <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/dmaFifo.sv
/*
 * DMA FIFO
 * Circular buffer of FIFO entries with read and write pointers,
 * an occupancy count and registered full and empty levels.
 * Head entry is read combinationally at the read pointer.
 */
`timescale 1ns/1ps
`default_nettype none

module dmaFifo #(
    parameter int unsigned FifoDepth = 8
) (
    input  wire                       BCLK,
    input  wire                       CCRESET_,
    input  wire sdmacPkg::fifoEntry_t pushEntry,
    input  wire                       push,
    input  wire                       pop,
    output sdmacPkg::fifoEntry_t      headEntry,
    output logic                      fifoFull,
    output logic                      fifoEmpty
);

    localparam int unsigned PtrWidth = $clog2(FifoDepth);

    sdmacPkg::fifoEntry_t mem [FifoDepth];

    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;
    logic [PtrWidth:0]   count;
    logic [PtrWidth:0]   nextCount;
    logic                doWrite;
    logic                doRead;

    assign doRead  = pop & ~fifoEmpty;
    // A full FIFO still takes a push when the head leaves in the same cycle
    assign doWrite = push & (~fifoFull | doRead);

    assign headEntry = mem[rdPtr];

    always_comb begin
        nextCount = count;
        case ({doWrite, doRead})
            2'b10:   nextCount = count + 1'b1;
            2'b01:   nextCount = count - 1'b1;
            default: nextCount = count;
        endcase
    end

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            count     <= '0;
            fifoFull  <= 1'b0;
            fifoEmpty <= 1'b1;
        end else begin
            // Power of two depth, pointers wrap on their own
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count     <= nextCount;
            fifoFull  <= (nextCount == (PtrWidth + 1)'(FifoDepth));
            fifoEmpty <= (nextCount == '0);
        end
    end

    always_ff @(posedge BCLK) begin
        if (doWrite) begin
            mem[wrPtr] <= pushEntry;
        end
    end

endmodule

`default_nettype wire

// File: design/cpuBusMaster.sv
/*
 * CPU bus master
 * Arbitrates for the 68030-style bus, writes FIFO entries to memory
 * and ends each cycle on DSACK. A 16-bit port gets the low half in a
 * second cycle at addr+2. Empty flush entries are popped without a
 * bus cycle, and popping a last word pulses stopFlush.
 */
`timescale 1ns/1ps
`default_nettype none

module cpuBusMaster (
    input  wire                       BCLK,
    input  wire                       CCRESET_,
    input  wire                       dmaEnable,
    input  wire [31:0]                startAddr,
    input  wire sdmacPkg::fifoEntry_t headEntry,
    input  wire                       fifoEmpty,
    input  wire                       busGrant,
    input  wire [1:0]                 dsack,
    output logic                      pop,
    output logic                      busRequest,
    output logic                      busGrantAck,
    output sdmacPkg::busCycle_t       busCycle,
    output logic                      stopFlush
);

    typedef enum logic [2:0] {
        StIdle,
        StRequest,
        StGrant,
        StStrobe,
        StHalfTwo,
        StRelease
    } state_t;

    state_t              state;
    logic [1:0]          dsackReg;
    logic                dmaEnableDly;
    logic                strobeOn;
    logic [31:0]         addrCount;
    logic [31:0]         cycleAddr;
    sdmacPkg::fifoWord_t cycleData;
    logic                cycleSize16;
    logic                headIsEmpty;
    logic                dsackSeen;
    logic                launchLong;
    logic                launchHalf;
    logic                entryDone;

    assign headIsEmpty = (headEntry.validBytes == 3'd0);
    assign dsackSeen   = (dsackReg != sdmacPkg::DsackNone);

    // A new cycle starts only once the slave has released DSACK
    assign launchLong = (state == StGrant) & ~dsackSeen;
    assign launchHalf = (state == StHalfTwo) & ~dsackSeen;

    // Entry finished on a 32-bit answer or at the end of the low half
    assign entryDone = (state == StStrobe) & dsackSeen
                     & ((dsackReg != sdmacPkg::Dsack16) | cycleSize16);

    always_comb begin
        busCycle.addr       = cycleAddr;
        busCycle.data       = cycleData;
        busCycle.size16     = cycleSize16;
        busCycle.addrStrobe = strobeOn;
        busCycle.dataStrobe = strobeOn;
    end

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state        <= StIdle;
            dsackReg     <= sdmacPkg::DsackNone;
            dmaEnableDly <= 1'b0;
            strobeOn     <= 1'b0;
            pop          <= 1'b0;
            busRequest   <= 1'b0;
            busGrantAck  <= 1'b0;
            stopFlush    <= 1'b0;
        end else begin
            // Asynchronous DSACK pair is registered once before use
            dsackReg     <= dsack;
            dmaEnableDly <= dmaEnable;
            pop          <= 1'b0;
            stopFlush    <= 1'b0;

            case (state)
                StIdle: begin
                    // Head and empty flag are stale while a pop is in flight
                    if (dmaEnable && !fifoEmpty && !pop) begin
                        if (headIsEmpty) begin
                            pop       <= 1'b1;
                            stopFlush <= headEntry.lastWord;
                        end else begin
                            busRequest <= 1'b1;
                            state      <= StRequest;
                        end
                    end
                end

                StRequest: begin
                    if (busGrant) begin
                        busRequest  <= 1'b0;
                        busGrantAck <= 1'b1;
                        state       <= StGrant;
                    end
                end

                StGrant: begin
                    if (launchLong) begin
                        strobeOn <= 1'b1;
                        state    <= StStrobe;
                    end
                end

                StStrobe: begin
                    if (dsackSeen) begin
                        strobeOn <= 1'b0;
                        if (entryDone) begin
                            pop       <= 1'b1;
                            stopFlush <= headEntry.lastWord;
                            state     <= StRelease;
                        end else begin
                            state <= StHalfTwo;
                        end
                    end
                end

                StHalfTwo: begin
                    if (launchHalf) begin
                        strobeOn <= 1'b1;
                        state    <= StStrobe;
                    end
                end

                StRelease: begin
                    // Bus is kept as long as entries remain
                    if (!pop) begin
                        if (fifoEmpty || !dmaEnable) begin
                            busGrantAck <= 1'b0;
                            state       <= StIdle;
                        end else if (headIsEmpty) begin
                            pop       <= 1'b1;
                            stopFlush <= headEntry.lastWord;
                        end else begin
                            state <= StGrant;
                        end
                    end
                end

                default: state <= StIdle;
            endcase
        end
    end

    always_ff @(posedge BCLK) begin
        if (dmaEnable && !dmaEnableDly) begin
            addrCount <= startAddr;
        end else if (entryDone) begin
            addrCount <= addrCount + sdmacPkg::AddrStepLong;
        end

        if (launchLong) begin
            cycleAddr          <= addrCount;
            cycleData.longWord <= headEntry.data.longWord;
            cycleSize16        <= 1'b0;
        end else if (launchHalf) begin
            // Low half goes out on the high data lines
            cycleAddr               <= addrCount + sdmacPkg::AddrStepHalf;
            cycleData.halves.hiWord <= headEntry.data.halves.loWord;
            cycleData.halves.loWord <= 16'h0000;
            cycleSize16             <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/sdmacTop.sv
/*
 * SCSI DMA controller top level, SCSI to memory direction
 * Byte collector feeds the DMA FIFO, the bus master drains it
 */
`timescale 1ns/1ps
`default_nettype none

module sdmacTop #(
    parameter int unsigned FifoDepth = 8
) (
    input  wire                       BCLK,
    input  wire                       CCRESET_,
    input  wire [7:0]                 scsiByte,
    input  wire                       scsiStrobe,
    output wire                       scsiReady,
    input  wire                       flushFifo,
    input  wire                       dmaEnable,
    input  wire [31:0]                startAddr,
    output wire                       busRequest,
    input  wire                       busGrant,
    output wire                       busGrantAck,
    output wire sdmacPkg::busCycle_t  busCycle,
    input  wire [1:0]                 dsack,
    output wire                       stopFlush
);

    wire sdmacPkg::fifoEntry_t pushEntry;
    wire sdmacPkg::fifoEntry_t headEntry;
    wire                       push;
    wire                       pop;
    wire                       fifoFull;
    wire                       fifoEmpty;

    scsiByteCollector uCollector (
        .BCLK       (BCLK),
        .CCRESET_   (CCRESET_),
        .scsiByte   (scsiByte),
        .scsiStrobe (scsiStrobe),
        .flushFifo  (flushFifo),
        .fifoFull   (fifoFull),
        .scsiReady  (scsiReady),
        .pushEntry  (pushEntry),
        .push       (push)
    );

    dmaFifo #(
        .FifoDepth (FifoDepth)
    ) uFifo (
        .BCLK      (BCLK),
        .CCRESET_  (CCRESET_),
        .pushEntry (pushEntry),
        .push      (push),
        .pop       (pop),
        .headEntry (headEntry),
        .fifoFull  (fifoFull),
        .fifoEmpty (fifoEmpty)
    );

    cpuBusMaster uBusMaster (
        .BCLK        (BCLK),
        .CCRESET_    (CCRESET_),
        .dmaEnable   (dmaEnable),
        .startAddr   (startAddr),
        .headEntry   (headEntry),
        .fifoEmpty   (fifoEmpty),
        .busGrant    (busGrant),
        .dsack       (dsack),
        .pop         (pop),
        .busRequest  (busRequest),
        .busGrantAck (busGrantAck),
        .busCycle    (busCycle),
        .stopFlush   (stopFlush)
    );

endmodule

`default_nettype wire

// File: verification/busSlaveModel.sv
/*
 * Bus slave model for the DMA testbench
 * Grants the bus after a jittered delay, answers each strobe cycle
 * with DSACK after a set number of wait states, and stores the
 * written bytes in a 4 KB byte memory
 */
`timescale 1ns/1ps
`default_nettype none

module busSlaveModel (
    input  wire                      BCLK,
    input  wire                      CCRESET_,
    input  wire                      port16,
    input  wire [7:0]                waitStates,
    input  wire                      busRequest,
    input  wire sdmacPkg::busCycle_t busCycle,
    output logic                     busGrant,
    output logic [1:0]               dsack,
    output int                       writeCount
);

    logic [7:0] mem [4096];
    logic [7:0] waitCount;
    logic [3:0] grantDelay;
    integer     seed;

    // Every byte of the 4 KB space gets a value tied to its full address
    function automatic logic [7:0] fillByte(input logic [11:0] addr);
        return addr[7:0] ^ {addr[11:8], ~addr[11:8]};
    endfunction

    task automatic fillMemory();
        for (int a = 0; a < 4096; a++) begin
            mem[a] = fillByte(12'(a));
        end
    endtask

    task automatic storeCycle();
        logic [11:0] base;
        base = busCycle.addr[11:0];
        mem[base]     = busCycle.data.longWord[31:24];
        mem[base + 1] = busCycle.data.longWord[23:16];
        // A 16-bit port only sees the upper data lines
        if (!port16 && !busCycle.size16) begin
            mem[base + 2] = busCycle.data.longWord[15:8];
            mem[base + 3] = busCycle.data.longWord[7:0];
        end
    endtask

    initial begin
        seed       = 14;
        busGrant   = 1'b0;
        dsack      = 2'b11;
        writeCount = 0;
        fillMemory();
    end

    always @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            busGrant   <= 1'b0;
            grantDelay <= 4'd1;
            dsack      <= 2'b11;
            waitCount  <= 8'd0;
        end else begin
            // Grant follows the request after a short random delay
            if (!busRequest) begin
                busGrant   <= 1'b0;
                grantDelay <= 4'(($random(seed) & 3) + 1);
            end else if (grantDelay != 4'd0) begin
                grantDelay <= grantDelay - 4'd1;
            end else begin
                busGrant <= 1'b1;
            end

            // A write cycle needs both strobes, DSACK is held until they drop
            if (!(busCycle.addrStrobe && busCycle.dataStrobe)) begin
                dsack     <= 2'b11;
                waitCount <= 8'd0;
            end else if (dsack == 2'b11) begin
                if (waitCount < waitStates) begin
                    waitCount <= waitCount + 8'd1;
                end else begin
                    dsack      <= port16 ? 2'b01 : 2'b00;
                    writeCount <= writeCount + 1;
                    storeCycle();
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/sdmacTb.sv
/*
 * Testbench for the SCSI-to-memory DMA path
 * Reads cases from a data file, streams SCSI bytes into the DUT,
 * optionally flushes, then checks the memory image held by the bus
 * slave model, the stopFlush count, back-pressure and idle levels
 */
`timescale 1ns/1ps
`default_nettype none

module sdmacTb;

    localparam int unsigned FifoDepth = 8;
    localparam int MaxCases = 16;
    localparam int Timeout  = 5000;

    logic        BCLK;
    logic        CCRESET_;
    logic [7:0]  scsiByte;
    logic        scsiStrobe;
    logic        flushFifo;
    logic        dmaEnable;
    logic [31:0] startAddr;
    logic        port16;
    logic [7:0]  waitStates;
    wire         scsiReady;
    wire         busRequest;
    wire         busGrant;
    wire         busGrantAck;
    wire         stopFlush;
    wire [1:0]   dsack;
    wire [31:0]  writeCount;
    wire sdmacPkg::busCycle_t busCycle;

    logic [31:0] cases [6*MaxCases];
    int          errorCount;
    int          stopCount = 0;
    int          notReadyCycles = 0;
    int          halfCycles = 0;
    logic        strobeDly = 1'b0;

    sdmacTop #(
        .FifoDepth (FifoDepth)
    ) UUT (
        .BCLK        (BCLK),
        .CCRESET_    (CCRESET_),
        .scsiByte    (scsiByte),
        .scsiStrobe  (scsiStrobe),
        .scsiReady   (scsiReady),
        .flushFifo   (flushFifo),
        .dmaEnable   (dmaEnable),
        .startAddr   (startAddr),
        .busRequest  (busRequest),
        .busGrant    (busGrant),
        .busGrantAck (busGrantAck),
        .busCycle    (busCycle),
        .dsack       (dsack),
        .stopFlush   (stopFlush)
    );

    busSlaveModel slave (
        .BCLK       (BCLK),
        .CCRESET_   (CCRESET_),
        .port16     (port16),
        .waitStates (waitStates),
        .busRequest (busRequest),
        .busCycle   (busCycle),
        .busGrant   (busGrant),
        .dsack      (dsack),
        .writeCount (writeCount)
    );

    initial BCLK = 1'b0;
    always #10 BCLK = ~BCLK;

    // Counts stopFlush pulses, cycles with the SCSI source held off
    // and strobe cycles that carry a low half
    always @(posedge BCLK) begin
        strobeDly <= busCycle.addrStrobe;
        if (stopFlush) begin
            stopCount <= stopCount + 1;
        end
        if (CCRESET_ && !scsiReady) begin
            notReadyCycles <= notReadyCycles + 1;
        end
        if (busCycle.addrStrobe === 1'b1 && !strobeDly && busCycle.size16) begin
            halfCycles <= halfCycles + 1;
        end
    end

    function automatic logic [7:0] fillByte(input logic [11:0] addr);
        return addr[7:0] ^ {addr[11:8], ~addr[11:8]};
    endfunction

    task automatic timedOut(input string what);
        $display("Timeout: %s never came", what);
        $display("tests failed");
        $finish;
    endtask

    task automatic sendBytes(input int count, input logic [7:0] first);
        int n;
        for (int i = 0; i < count; i++) begin
            @(posedge BCLK);
            n = 0;
            while (!scsiReady) begin
                scsiStrobe <= 1'b0;
                if (n == Timeout) timedOut("scsiReady during the byte stream");
                n++;
                @(posedge BCLK);
            end
            scsiStrobe <= 1'b1;
            scsiByte   <= first + 8'(i);
        end
        @(posedge BCLK);
        scsiStrobe <= 1'b0;
    endtask

    task automatic waitReady();
        int n;
        n = 0;
        // A word completed by the last byte shows in fifoFull two edges later
        repeat (2) @(posedge BCLK);
        while (!scsiReady) begin
            if (n == Timeout) timedOut("scsiReady before the flush");
            n++;
            @(posedge BCLK);
        end
    endtask

    task automatic waitWrites(input int target);
        int n;
        n = 0;
        while (int'(writeCount) < target) begin
            if (n == Timeout) timedOut("the last bus write");
            n++;
            @(posedge BCLK);
        end
    endtask

    task automatic waitStops(input int target);
        int n;
        n = 0;
        while (stopCount < target) begin
            if (n == Timeout) timedOut("the stopFlush pulse");
            n++;
            @(posedge BCLK);
        end
    endtask

    task automatic waitRelease();
        int n;
        n = 0;
        while (busGrantAck) begin
            if (n == Timeout) timedOut("the bus release");
            n++;
            @(posedge BCLK);
        end
    endtask

    // Bus outputs and stopFlush low, SCSI source allowed to send
    task automatic checkIdle(input int idx);
        if ({busRequest, busGrantAck, busCycle.addrStrobe, busCycle.dataStrobe,
             stopFlush, scsiReady} !== 6'b000001) begin
            errorCount++;
            $display("[ERROR] %0t: case %0d idle levels req/ack/as/ds/stop/ready = %b",
                     $time, idx, {busRequest, busGrantAck, busCycle.addrStrobe,
                     busCycle.dataStrobe, stopFlush, scsiReady});
        end
    endtask

    // Data bytes, then zero padding, then four untouched bytes
    task automatic checkMemory(input int idx, input logic [31:0] addr,
                               input int count, input logic [7:0] first, input int padded);
        logic [7:0]  expected;
        logic [11:0] a;
        for (int k = 0; k < padded + 4; k++) begin
            a = 12'(addr + 32'(k));
            if (k < count) begin
                expected = first + 8'(k);
            end else if (k < padded) begin
                expected = 8'h00;
            end else begin
                expected = fillByte(a);
            end
            if (slave.mem[a] !== expected) begin
                errorCount++;
                $display("[ERROR] %0t: case %0d byte at %h is %h, expected %h",
                         $time, idx, a, slave.mem[a], expected);
            end
        end
    endtask

    task automatic runCase(input int idx);
        logic [31:0] width;
        logic [31:0] waits;
        logic [31:0] addr;
        logic [31:0] count;
        logic [31:0] first;
        logic [31:0] flush;
        int words;
        int writes;
        int halves;
        int writeBase;
        int stopBase;
        int readyBase;
        int halfBase;
        width = cases[idx*6];
        waits = cases[idx*6+1];
        addr  = cases[idx*6+2];
        count = cases[idx*6+3];
        first = cases[idx*6+4];
        flush = cases[idx*6+5];
        // A partial word is padded to a full longword
        words  = (int'(count) + sdmacPkg::BytesPerWord - 1) / sdmacPkg::BytesPerWord;
        writes = (width == 32'h10) ? 2 * words : words;
        halves = (width == 32'h10) ? words : 0;
        slave.fillMemory();
        writeBase = int'(writeCount);
        stopBase  = stopCount;
        readyBase = notReadyCycles;
        halfBase  = halfCycles;

        @(posedge BCLK);
        port16     <= (width == 32'h10);
        waitStates <= waits[7:0];
        startAddr  <= addr;
        dmaEnable  <= 1'b1;
        sendBytes(int'(count), first[7:0]);
        if (flush != 0) begin
            waitReady();
            flushFifo <= 1'b1;
        end
        waitWrites(writeBase + writes);
        if (flush != 0) waitStops(stopBase + 1);
        waitRelease();
        repeat (8) @(posedge BCLK);
        dmaEnable <= 1'b0;
        flushFifo <= 1'b0;
        @(posedge BCLK);

        checkIdle(idx);
        if (int'(writeCount) - writeBase != writes) begin
            errorCount++;
            $display("[ERROR] %0t: case %0d saw %0d bus writes, expected %0d",
                     $time, idx, int'(writeCount) - writeBase, writes);
        end
        if (halfCycles - halfBase != halves) begin
            errorCount++;
            $display("[ERROR] %0t: case %0d saw %0d low-half cycles, expected %0d",
                     $time, idx, halfCycles - halfBase, halves);
        end
        if (stopCount - stopBase != ((flush != 0) ? 1 : 0)) begin
            errorCount++;
            $display("[ERROR] %0t: case %0d saw %0d stopFlush pulses",
                     $time, idx, stopCount - stopBase);
        end
        if (count > FifoDepth * sdmacPkg::BytesPerWord && waits >= 8
                && notReadyCycles == readyBase) begin
            errorCount++;
            $display("[ERROR] %0t: case %0d scsiReady never went low", $time, idx);
        end
        checkMemory(idx, addr, int'(count), first[7:0], words * sdmacPkg::BytesPerWord);
    endtask

    initial begin
        int idx;
        errorCount = 0;
        CCRESET_   = 1'b0;
        scsiByte   = 8'h00;
        scsiStrobe = 1'b0;
        flushFifo  = 1'b0;
        dmaEnable  = 1'b0;
        startAddr  = 32'h0;
        port16     = 1'b0;
        waitStates = 8'd0;
        for (int i = 0; i < 6 * MaxCases; i++) begin
            cases[i] = '1;
        end
        $readmemh("verification/sdmacCases.txt", cases);

        repeat (10) @(posedge BCLK);
        CCRESET_ <= 1'b1;
        @(posedge BCLK);
        checkIdle(-1);

        idx = 0;
        while (idx < MaxCases && cases[idx*6] != '1) begin
            runCase(idx);
            idx++;
        end
        if (idx == 0) begin
            errorCount++;
            $display("No cases could be read from the cases file");
        end

        $display("Cases run: %0d, errors: %0d", idx, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/sdmacCases.txt
// One case per line, all fields hex
// port width (10 or 20), wait states, start address, byte count, first byte, flush
// 32-bit port, whole longwords
20 0 100 20 01 0
// 16-bit port, same bytes as above
10 0 100 20 01 0
// Flush after a partial word of 3 bytes
20 1 200 0B 40 1
// 16-bit port, flush after a partial word of 1 byte
10 2 300 0D 80 1
// Flush with no partial bytes
20 0 400 10 A0 1
10 1 480 08 C0 1
// Long wait states, more bytes than the FIFO holds
20 C 600 60 10 0
10 8 800 50 33 1
// Short transfer ending in a flush
20 3 A00 07 F0 1

// File: verilog.f
design/sdmacPkg.sv
design/scsiByteCollector.sv
design/dmaFifo.sv
design/cpuBusMaster.sv
design/sdmacTop.sv
verification/busSlaveModel.sv
verification/sdmacTb.sv

// File: Bender.yml
package:
  name: sdmac

sources:
  - design/sdmacPkg.sv
  - design/scsiByteCollector.sv
  - design/dmaFifo.sv
  - design/cpuBusMaster.sv
  - design/sdmacTop.sv
  - target: test
    files:
      - verification/busSlaveModel.sv
      - verification/sdmacTb.sv
